// File: common/rv_isa_pkg.sv
/*
  RV32I subset encodings for the multicycle core.
  Only the major opcodes and funct3 values that the core executes are listed.
  Core FSM states are shared here so that checks outside the core can name them.
*/
package rv_isa_pkg;

    localparam int xlen_p       = 32;
    localparam int reg_addr_w_p = 5;
    localparam int num_regs_p   = 32;
    localparam logic [xlen_p-1:0] reset_pc_p = 32'h0000_0000;
    localparam logic [xlen_p-1:0] pc_step_p  = 32'd4;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_xor     = 3'b100,
        f3_srl     = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_alu_e;

    typedef enum logic [2:0] {
        f3_beq = 3'b000,
        f3_bne = 3'b001,
        f3_blt = 3'b100,
        f3_bge = 3'b101
    } funct3_br_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_xor, alu_or, alu_and,
        alu_sll, alu_srl, alu_pass_b, alu_link
    } alu_op_e;

    typedef enum logic [1:0] {
        st_fetch, st_execute, st_mem, st_writeback
    } core_state_e;

endpackage

// File: common/wb_pkg.sv
/*
  Wishbone classic bus constants.
  Word transfers only, so the byte select is always all ones.
*/
package wb_pkg;

    localparam int wb_adr_w_p = 32;
    localparam int wb_dat_w_p = 32;
    localparam logic [3:0] wb_sel_all_p = 4'b1111;

    // bus master cycle type
    typedef enum logic [1:0] {
        wb_idle  = 2'd0,
        wb_write = 2'd1,
        wb_read  = 2'd2
    } wb_state_e;

endpackage

// File: common/core_ifs.sv
/*
  Core internal interfaces.
  mem_req_if: single outstanding request, addr and wdata held until done.
  decode_if: decoded fields and control flags of the current instruction.
*/
`timescale 1ns/1ps

interface mem_req_if import wb_pkg::*; ();
    logic                  rd_req;   // one-cycle pulses
    logic                  wr_req;
    logic [wb_adr_w_p-1:0] addr;
    logic [wb_dat_w_p-1:0] wdata;
    logic [wb_dat_w_p-1:0] rdata;    // valid with done
    logic                  done;

    modport core (output rd_req, wr_req, addr, wdata, input rdata, done);
    modport bus  (input rd_req, wr_req, addr, wdata, output rdata, done);
endinterface

interface decode_if import rv_isa_pkg::*; ();
    opcode_e                 opcode;
    alu_op_e                 alu_op;
    logic [2:0]              funct3;
    logic [reg_addr_w_p-1:0] rs1;
    logic [reg_addr_w_p-1:0] rs2;
    logic [reg_addr_w_p-1:0] rd;
    logic [xlen_p-1:0]       imm;
    logic                    use_imm;
    logic                    reg_we;
    logic                    is_load;
    logic                    is_store;
    logic                    is_branch;
    logic                    is_jal;
    logic                    is_jalr;

    modport dec  (output opcode, alu_op, funct3, rs1, rs2, rd, imm, use_imm, reg_we,
                  is_load, is_store, is_branch, is_jal, is_jalr);
    modport user (input opcode, alu_op, funct3, rs1, rs2, rd, imm, use_imm, reg_we,
                  is_load, is_store, is_branch, is_jal, is_jalr);
endinterface

// File: core/instr_decode.sv
/*
  Combinational RV32I subset decoder.
  Immediates are sign-extended per RV32I. srai is not supported.
  Unknown opcodes clear every flag and so execute as a no-op.
*/
`timescale 1ns/1ps

module instr_decode import rv_isa_pkg::*; (
    input  logic [xlen_p-1:0] instr_i,
    decode_if.dec             dec
);

    logic [xlen_p-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub_en);
        alu_op_e op_sel;
        case (funct3_alu_e'(f3))
            f3_add_sub: op_sel = sub_en ? alu_sub : alu_add;
            f3_sll:     op_sel = alu_sll;
            f3_xor:     op_sel = alu_xor;
            f3_srl:     op_sel = alu_srl;
            f3_or:      op_sel = alu_or;
            f3_and:     op_sel = alu_and;
            default:    op_sel = alu_add;   // slt/sltu not in subset
        endcase
        return op_sel;
    endfunction

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        dec.opcode    = opcode_e'(instr_i[6:0]);
        dec.funct3    = instr_i[14:12];
        dec.rs1       = instr_i[19:15];
        dec.rs2       = instr_i[24:20];
        dec.rd        = instr_i[11:7];
        dec.alu_op    = alu_add;
        dec.imm       = imm_i;
        dec.use_imm   = 1'b0;
        dec.reg_we    = 1'b0;
        dec.is_load   = 1'b0;
        dec.is_store  = 1'b0;
        dec.is_branch = 1'b0;
        dec.is_jal    = 1'b0;
        dec.is_jalr   = 1'b0;
        case (instr_i[6:0])
            opc_op: begin
                dec.reg_we = 1'b1;
                dec.alu_op = alu_from_f3(instr_i[14:12], instr_i[30]);
            end
            opc_op_imm: begin
                dec.reg_we  = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = alu_from_f3(instr_i[14:12], 1'b0);  // no subi
            end
            opc_lui: begin
                dec.reg_we  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = alu_pass_b;
            end
            opc_load: begin
                dec.reg_we  = 1'b1;
                dec.use_imm = 1'b1;
                dec.is_load = 1'b1;
            end
            opc_store: begin
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                dec.imm      = imm_s;
            end
            opc_branch: begin
                dec.is_branch = 1'b1;
                dec.imm       = imm_b;
            end
            opc_jal: begin
                dec.reg_we = 1'b1;
                dec.is_jal = 1'b1;
                dec.imm    = imm_j;
                dec.alu_op = alu_link;
            end
            opc_jalr: begin
                dec.reg_we  = 1'b1;
                dec.is_jalr = 1'b1;
                dec.alu_op  = alu_link;
            end
            default: ;
        endcase
    end

endmodule

// File: core/alu.sv
/*
  Datapath arithmetic for one instruction.
  result_o serves ALU ops, lui, link values and load/store addresses.
  Branch compares are signed only (no bltu/bgeu).
*/
`timescale 1ns/1ps

module alu import rv_isa_pkg::*; (
    decode_if.user            dec,
    input  logic [xlen_p-1:0] rs1_data_i,
    input  logic [xlen_p-1:0] rs2_data_i,
    input  logic [xlen_p-1:0] pc_i,
    output logic [xlen_p-1:0] result_o,
    output logic [xlen_p-1:0] target_o,
    output logic              branch_take_o
);

    logic [xlen_p-1:0] op_b;

    assign op_b = dec.use_imm ? dec.imm : rs2_data_i;

    always_comb begin
        case (dec.alu_op)
            alu_add:    result_o = rs1_data_i + op_b;
            alu_sub:    result_o = rs1_data_i - op_b;
            alu_xor:    result_o = rs1_data_i ^ op_b;
            alu_or:     result_o = rs1_data_i | op_b;
            alu_and:    result_o = rs1_data_i & op_b;
            alu_sll:    result_o = rs1_data_i << op_b[4:0];
            alu_srl:    result_o = rs1_data_i >> op_b[4:0];
            alu_pass_b: result_o = op_b;                 // lui
            alu_link:   result_o = pc_i + pc_step_p;
            default:    result_o = '0;
        endcase
    end

    // jalr is register relative, branches and jal are pc relative
    assign target_o = ((dec.opcode == opc_jalr) ? rs1_data_i : pc_i) + dec.imm;

    always_comb begin
        case (dec.funct3)
            f3_beq:  branch_take_o = (rs1_data_i == rs2_data_i);
            f3_bne:  branch_take_o = (rs1_data_i != rs2_data_i);
            f3_blt:  branch_take_o = ($signed(rs1_data_i) <  $signed(rs2_data_i));
            f3_bge:  branch_take_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            default: branch_take_o = 1'b0;
        endcase
    end

endmodule

// File: core/reg_file.sv
/*
  32 x 32 register file, two combinational read ports, one write port.
  x0 is never written and reads as zero.
*/
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    decode_if.user            dec,
    input  logic              we_i,
    input  logic [xlen_p-1:0] wdata_i,
    output logic [xlen_p-1:0] rs1_data_o,
    output logic [xlen_p-1:0] rs2_data_o
);

    logic [xlen_p-1:0] regs [num_regs_p];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs_p; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && dec.rd != '0) begin
            regs[dec.rd] <= wdata_i;
        end
    end

    assign rs1_data_o = regs[dec.rs1];
    assign rs2_data_o = regs[dec.rs2];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (dec.rs1 == '0) |-> (rs1_data_o == '0));

endmodule

// File: core/core_ctrl.sv
/*
  PC, instruction register and the multicycle sequencer.
  fetch -> execute -> (mem -> writeback) -> fetch, one instruction in flight.
  Bus latency is absorbed by waiting on done; no timeout.
*/
`timescale 1ns/1ps

module core_ctrl import rv_isa_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    decode_if.user            dec,
    input  logic [xlen_p-1:0] alu_result_i,
    input  logic [xlen_p-1:0] alu_target_i,
    input  logic              branch_take_i,
    input  logic [xlen_p-1:0] rs2_data_i,
    mem_req_if.core           mem,
    output logic [xlen_p-1:0] instr_o,
    output logic [xlen_p-1:0] pc_o,
    output logic              rf_we_o,
    output logic [xlen_p-1:0] rf_wdata_o
);

    core_state_e       state;
    logic              pending;   // bus request outstanding
    logic              req;
    logic [xlen_p-1:0] pc;
    logic [xlen_p-1:0] ir;
    logic [xlen_p-1:0] load_q;
    logic [xlen_p-1:0] next_pc;

    // one pulse on entry to fetch or mem
    assign req        = (state == st_fetch || state == st_mem) && !pending;
    assign mem.wr_req = req && state == st_mem && dec.is_store;
    assign mem.rd_req = req && !(state == st_mem && dec.is_store);
    assign mem.addr   = (state == st_mem) ? alu_result_i : pc;  // ir stable, so addr holds
    assign mem.wdata  = rs2_data_i;

    always_comb begin
        if (dec.is_jalr) begin
            next_pc = {alu_target_i[xlen_p-1:1], 1'b0};
        end else if (dec.is_jal || (dec.is_branch && branch_take_i)) begin
            next_pc = alu_target_i;
        end else begin
            next_pc = pc + pc_step_p;  // also unknown opcodes
        end
    end

    assign rf_we_o    = (state == st_execute && dec.reg_we && !dec.is_load) ||
                        (state == st_writeback && dec.reg_we);
    assign rf_wdata_o = (state == st_writeback) ? load_q : alu_result_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_fetch;
            pending <= 1'b0;
            pc      <= reset_pc_p;
        end else begin
            if (req) begin
                pending <= 1'b1;
            end else if (mem.done) begin
                pending <= 1'b0;
            end
            case (state)
                st_fetch: begin
                    if (mem.done) state <= st_execute;
                end
                st_execute: begin
                    pc    <= next_pc;
                    state <= (dec.is_load || dec.is_store) ? st_mem : st_fetch;
                end
                st_mem: begin
                    if (mem.done) state <= dec.is_load ? st_writeback : st_fetch;
                end
                default: state <= st_fetch;  // writeback lasts one cycle
            endcase
        end
    end

    // rdata only valid with done
    always_ff @(posedge clk) begin
        if (state == st_fetch && mem.done) ir <= mem.rdata;
        if (state == st_mem && mem.done) load_q <= mem.rdata;
    end

    assign instr_o = ir;
    assign pc_o    = pc;

    a_single_req: assert property (@(posedge clk) disable iff (rst)
        (mem.rd_req || mem.wr_req) |=>
            (!mem.rd_req && !mem.wr_req) throughout mem.done[->1]);

    // execute follows a fetch done, writeback follows a load done
    a_rf_we_after_done: assert property (@(posedge clk) disable iff (rst)
        rf_we_o |-> $past(mem.done));

endmodule

// File: logic/wb_master.sv
/*
  Wishbone classic-cycle manager, one core request at a time.
  Outputs are registered: cyc/stb rise the cycle after the request pulse
  and drop the cycle after ack, together with a one-cycle done.
*/
`timescale 1ns/1ps

module wb_master import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [wb_dat_w_p-1:0] dat_i,
    input  logic                  ack_i,
    mem_req_if.bus                mem,
    output logic [wb_adr_w_p-1:0] adr_o,
    output logic [wb_dat_w_p-1:0] dat_o,
    output logic [3:0]            sel_o,
    output logic                  we_o,
    output logic                  stb_o,
    output logic                  cyc_o
);

    wb_state_e             state;
    logic                  done_q;
    logic [wb_dat_w_p-1:0] rdata_q;
    logic                  start;

    assign start = (state == wb_idle) && (mem.rd_req || mem.wr_req);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= wb_idle;
            cyc_o  <= 1'b0;
            stb_o  <= 1'b0;
            we_o   <= 1'b0;
            sel_o  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                state <= mem.wr_req ? wb_write : wb_read;
                cyc_o <= 1'b1;
                stb_o <= 1'b1;
                we_o  <= mem.wr_req;
                sel_o <= wb_sel_all_p;
            end else if (state != wb_idle && ack_i) begin
                state  <= wb_idle;
                cyc_o  <= 1'b0;
                stb_o  <= 1'b0;
                we_o   <= 1'b0;
                sel_o  <= '0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_o <= mem.addr;
            dat_o <= mem.wdata;
        end
        if (state == wb_read && ack_i) rdata_q <= dat_i;
    end

    assign mem.done  = done_q;
    assign mem.rdata = rdata_q;

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb_o |-> cyc_o);

    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (stb_o && !ack_i) |=> $stable(adr_o));

endmodule

// File: logic/rv_wb_top.sv
/*
  RV32I subset core with a Wishbone classic master port.
  Instructions and data share the bus; program starts at address 0.
*/
`timescale 1ns/1ps

module rv_wb_top
    import rv_isa_pkg::*;
    import wb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [wb_dat_w_p-1:0] wb_dat_i,
    input  logic                  wb_ack_i,
    output logic [wb_adr_w_p-1:0] wb_adr_o,
    output logic [wb_dat_w_p-1:0] wb_dat_o,
    output logic [3:0]            wb_sel_o,
    output logic                  wb_we_o,
    output logic                  wb_stb_o,
    output logic                  wb_cyc_o
);

    mem_req_if mem ();
    decode_if  dec ();

    logic [xlen_p-1:0] instr;
    logic [xlen_p-1:0] pc;
    logic [xlen_p-1:0] alu_result;
    logic [xlen_p-1:0] alu_target;
    logic [xlen_p-1:0] rs1_data;
    logic [xlen_p-1:0] rs2_data;
    logic [xlen_p-1:0] rf_wdata;
    logic              branch_take;
    logic              rf_we;

    core_ctrl u_ctrl (
        .clk(clk), .rst(rst), .dec(dec),
        .alu_result_i(alu_result), .alu_target_i(alu_target),
        .branch_take_i(branch_take), .rs2_data_i(rs2_data), .mem(mem),
        .instr_o(instr), .pc_o(pc), .rf_we_o(rf_we), .rf_wdata_o(rf_wdata)
    );

    instr_decode u_decode (.instr_i(instr), .dec(dec));

    alu u_alu (
        .dec(dec), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .pc_i(pc),
        .result_o(alu_result), .target_o(alu_target), .branch_take_o(branch_take)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .dec(dec), .we_i(rf_we), .wdata_i(rf_wdata),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    wb_master u_wb (
        .clk(clk), .rst(rst), .dat_i(wb_dat_i), .ack_i(wb_ack_i), .mem(mem),
        .adr_o(wb_adr_o), .dat_o(wb_dat_o), .sel_o(wb_sel_o),
        .we_o(wb_we_o), .stb_o(wb_stb_o), .cyc_o(wb_cyc_o)
    );

endmodule

// File: verif/tb_checker.sv
/*
  Bus monitor: compares every acked write with the expected store records
  and checks reset idle, first fetch, byte select and request stability.
  Records start at word 0x102 as (test, address, data) triples.
*/
`timescale 1ns/1ps

module tb_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    input  logic [3:0]  sel,
    input  logic        we,
    input  logic        stb,
    input  logic        cyc,
    input  logic        ack,
    output logic        done_o,
    output int          err_o
);

    logic [31:0] pat [0:511];
    int          rec_total;
    int          rec_idx;
    int          cur_err;
    int          pass_cnt;
    int          fail_cnt;
    logic        seen_fetch;
    logic        hold_v;
    logic [31:0] hold_adr;
    logic [31:0] hold_dat;
    logic        hold_we;

    function automatic logic [31:0] rec_word(input int idx, input int field);
        return pat[9'(258 + 3 * idx + field)];
    endfunction

    task automatic count_error();
        cur_err++;
        err_o++;
    endtask

    task automatic close_test(input logic [31:0] num);
        if (cur_err == 0) begin
            pass_cnt++;
            $display("test %0d: pass", num);
        end else begin
            fail_cnt++;
            $display("test %0d: fail with %0d errors", num, cur_err);
        end
        cur_err = 0;
    endtask

    task automatic check_store();
        logic [31:0] exp_adr;
        logic [31:0] exp_dat;
        logic [31:0] num;
        if (rec_idx >= rec_total) begin
            $display("unexpected store to %h after the last expected record", adr);
            count_error();
            return;
        end
        num     = rec_word(rec_idx, 0);
        exp_adr = rec_word(rec_idx, 1);
        exp_dat = rec_word(rec_idx, 2);
        if (adr != exp_adr || dat_w != exp_dat) begin
            $display("Fail t=%0t addr=%h expected %h:%h actual %h:%h",
                     $time, adr, exp_adr, exp_dat, adr, dat_w);
            count_error();
        end
        rec_idx++;
        if (rec_idx == rec_total || rec_word(rec_idx, 0) != num) close_test(num);
        if (rec_idx == rec_total) begin
            $display("checker: %0d tests passed, %0d failed, %0d errors",
                     pass_cnt, fail_cnt, err_o);
            done_o = 1'b1;
        end
    endtask

    initial begin
        done_o     = 1'b0;
        err_o      = 0;
        rec_idx    = 0;
        cur_err    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        seen_fetch = 1'b0;
        hold_v     = 1'b0;
        $readmemh("verif/program_patterns.hex", pat);
        rec_total = pat[9'h101];
    end

    always @(posedge clk) begin
        if (rst) begin
            if (cyc || stb || we || sel != 4'h0) begin
                $display("bus was active while reset was asserted");
                count_error();
            end
        end else begin
            if (cyc && !seen_fetch) begin
                seen_fetch = 1'b1;
                if (adr != 32'h0 || we) begin
                    $display("Fail t=%0t first fetch addr=%h we=%b expected a read at 00000000",
                             $time, adr, we);
                    count_error();
                end
            end
            if (stb && sel != 4'hf) begin
                $display("Fail t=%0t byte select %h expected f", $time, sel);
                count_error();
            end
            if (hold_v &&
                (!stb || adr != hold_adr || dat_w != hold_dat || we != hold_we)) begin
                $display("bus request changed or dropped at %0t before ack", $time);
                count_error();
            end
            hold_v   = stb && !ack;
            hold_adr = adr;
            hold_dat = dat_w;
            hold_we  = we;
            if (cyc && stb && we && ack) check_store();
        end
    end

endmodule

// File: verif/tb_top.sv
/*
  Testbench top: clock, reset, shared program/data memory and watchdog.
  Memory is 512 words, indexed by adr[10:2]; higher address bits are ignored.
  Ack comes 0 to 3 cycles after stb, driven on the falling edge.
*/
`timescale 1ns/1ps

module tb_top;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    logic [31:0] wb_adr_o;
    logic [31:0] wb_dat_o;
    logic [3:0]  wb_sel_o;
    logic        wb_we_o;
    logic        wb_stb_o;
    logic        wb_cyc_o;

    logic [31:0] mem [0:511];
    int unsigned wait_cnt;
    int unsigned limit_cycles;
    logic        chk_done;
    int          chk_errors;
    logic        timed_out;

    always #10 clk = ~clk;  // 20 ns period

    rv_wb_top dut (
        .clk(clk), .rst(rst), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
        .wb_we_o(wb_we_o), .wb_stb_o(wb_stb_o), .wb_cyc_o(wb_cyc_o)
    );

    tb_checker u_checker (
        .clk(clk), .rst(rst), .adr(wb_adr_o), .dat_w(wb_dat_o), .sel(wb_sel_o),
        .we(wb_we_o), .stb(wb_stb_o), .cyc(wb_cyc_o), .ack(wb_ack_i),
        .done_o(chk_done), .err_o(chk_errors)
    );

    // Wishbone slave memory, one ack per cycle
    always @(negedge clk) begin
        if (rst) begin
            wb_ack_i <= 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i <= 1'b0;  // master drops stb after the acked edge
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wait_cnt == 0) begin
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem[wb_adr_o[10:2]];
                if (wb_we_o) mem[wb_adr_o[10:2]] <= wb_dat_o;
                wait_cnt <= $urandom % 4;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    initial begin
        void'($urandom(32'h9d998719));
        rst       = 1'b1;
        wb_ack_i  = 1'b0;
        wb_dat_i  = '0;
        timed_out = 1'b0;
        wait_cnt  = $urandom % 4;
        $readmemh("verif/program_patterns.hex", mem);
        limit_cycles = 40 * mem[9'h100] * 8;  // word 0x100 holds the program length
        repeat (16) @(negedge clk);
        rst = 1'b0;
        fork
            wait (chk_done);
            begin
                repeat (limit_cycles) @(posedge clk);
                timed_out = 1'b1;
            end
        join_any
        disable fork;
        if (timed_out) begin
            $display("timeout: the program did not reach its final store in %0d cycles",
                     limit_cycles);
        end
        if (!timed_out && chk_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/program_patterns.hex
// program words from 0x000, data words from 0x100, stores land at 0x200
// word 0x100: program word count, 0x101: record count
// records from 0x102: test number, store address, store data
@000
20000093 FFB00113 00C00193 00310233 0040A023 402182B3 0050A223 00314333
0060A423 003163B3 00317433 003194B3 00315533 0070A623 0080A823 0090AA23
00A0AC23 FFF1C593 7001E613 0F017693 00419713 01C15793 00B0AE23 02C0A023
02D0A223 02E0A423 02F0A623 12345837 0300A823 F000A883 F040A903 0310AA23
0320AC23 05500013 0200AE23 11100A93 00318463 0420A023 00310463 0550A023
00311463 0420A223 00319463 0550A223 00314463 0420A423 0021C463 0550A423
0021D463 0420A623 00315463 0550A623 00C00B6F 0420A823 0420A823 0560A823
015B0BE7 0420AA23 0570AA23 1F50AE23 0000006F
@040
CAFEF00D 80000001
@100
0000003D 00000017
00000001 00000200 00000007
00000001 00000204 00000011
00000001 00000208 FFFFFFF7
00000001 0000020C FFFFFFFF
00000001 00000210 00000008
00000001 00000214 0000C000
00000001 00000218 000FFFFF
00000002 0000021C FFFFFFF3
00000002 00000220 0000070C
00000002 00000224 000000F0
00000002 00000228 000000C0
00000002 0000022C 0000000F
00000003 00000230 12345000
00000003 00000234 CAFEF00D
00000003 00000238 80000001
00000003 0000023C 00000000
00000004 00000240 00000111
00000004 00000244 00000111
00000004 00000248 00000111
00000004 0000024C 00000111
00000005 00000250 000000D4
00000005 00000254 000000E4
00000006 000003FC 00000111

// File: rv_wb_top.f
common/rv_isa_pkg.sv
common/wb_pkg.sv
common/core_ifs.sv
core/instr_decode.sv
core/alu.sv
core/reg_file.sv
core/core_ctrl.sv
logic/wb_master.sv
logic/rv_wb_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status reflects the result.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_wb_top.f --top-module tb_top \
    -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
